// File: hdl/bridge_macros.svh
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// Streamer side
`define BRIDGE_STREAMERS   2
`define BRIDGE_MAX_READS   4
`define BRIDGE_READ_SLOTS  (`BRIDGE_STREAMERS * `BRIDGE_MAX_READS)

// Widths
`define BRIDGE_DATA_W      32
`define BRIDGE_ADDR_W      32
`define BRIDGE_WADDR_W     12
`define BRIDGE_XY_W        3

// Word address starts at this byte address bit
`define BRIDGE_WADDR_LSB   2

// Scratchpad tile coordinates
`define BRIDGE_SPM_X       0
`define BRIDGE_SPM_Y       1

// NoC opcodes
`define BRIDGE_OP_MPUT     4
`define BRIDGE_OP_MGET     5

// Short header layout
`define BRIDGE_HDR_DST_LO  0
`define BRIDGE_HDR_DST_HI  5
`define BRIDGE_HDR_ADDR_LO 6
`define BRIDGE_HDR_ADDR_HI 17
`define BRIDGE_HDR_SRC_LO  18
`define BRIDGE_HDR_SRC_HI  23
`define BRIDGE_HDR_PT      24
`define BRIDGE_HDR_OP_LO   25
`define BRIDGE_HDR_OP_HI   27
`define BRIDGE_HDR_HL      28

`endif

// File: hdl/bridge_pkg.sv
`include "bridge_macros.svh"

package bridge_pkg;

    typedef logic [$clog2(`BRIDGE_STREAMERS)-1:0]        streamer_id_t;
    typedef logic [`BRIDGE_STREAMERS-1:0]                streamer_vec_t;
    typedef logic [`BRIDGE_ADDR_W-1:0]                   tcdm_addr_t;
    typedef logic [`BRIDGE_DATA_W-1:0]                   tcdm_data_t;
    typedef logic [`BRIDGE_WADDR_W-1:0]                  word_addr_t;
    typedef logic [`BRIDGE_XY_W-1:0]                     tile_xy_t;

    // Y coordinate in the upper half
    typedef logic [2*`BRIDGE_XY_W-1:0]                   tile_id_t;
    typedef logic [`BRIDGE_HDR_OP_HI-`BRIDGE_HDR_OP_LO:0] opcode_t;
    typedef logic [$clog2(`BRIDGE_MAX_READS+1)-1:0]      read_count_t;

    // Outstanding-read table indexing
    typedef logic [$clog2(`BRIDGE_READ_SLOTS)-1:0]       slot_idx_t;
    typedef logic [$clog2(`BRIDGE_READ_SLOTS+1)-1:0]     slot_count_t;

    // wen high means read
    typedef struct packed {
        tcdm_addr_t addr;
        logic       wen;
        tcdm_data_t data;
    } tcdm_req_t;

    typedef struct packed {
        tcdm_data_t data;
        logic       last;
    } noc_beat_t;

    typedef struct packed {
        streamer_id_t sid;
        word_addr_t   waddr;
    } read_entry_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEADER,
        TX_DATA
    } tx_state_t;

    typedef enum logic {
        RX_HEADER,
        RX_DATA
    } rx_state_t;

endpackage

// File: hdl/req_arbiter.sv
`include "bridge_macros.svh"

module req_arbiter (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  bridge_pkg::streamer_vec_t                     req_i,
    input  bridge_pkg::tcdm_req_t [`BRIDGE_STREAMERS-1:0] reqs_i,
    input  bridge_pkg::streamer_vec_t                     room_i,
    input  logic                                          tx_idle_i,
    output bridge_pkg::streamer_vec_t                     gnt_o,
    output logic                                          grant_valid_o,
    output bridge_pkg::streamer_id_t                      grant_id_o,
    output bridge_pkg::tcdm_req_t                         grant_req_o
);

    import bridge_pkg::*;

    streamer_vec_t eligible;
    streamer_id_t  prio_q;
    streamer_id_t  scan_id;
    streamer_id_t  pick;
    logic          found;

    assign eligible = req_i & room_i;

    // First eligible streamer at or after the priority pointer
    always_comb begin
        found   = 1'b0;
        pick    = prio_q;
        scan_id = prio_q;
        for (int unsigned k = 0; k < `BRIDGE_STREAMERS; k++) begin
            scan_id = streamer_id_t'((prio_q + k) % `BRIDGE_STREAMERS);
            if (!found && eligible[scan_id]) begin
                found = 1'b1;
                pick  = scan_id;
            end
        end
    end

    assign grant_valid_o = found & tx_idle_i;
    assign grant_id_o    = pick;
    assign grant_req_o   = reqs_i[pick];

    always_comb begin
        gnt_o       = '0;
        gnt_o[pick] = grant_valid_o;
    end

    // Pointer moves past the granted streamer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= '0;
        end else if (grant_valid_o) begin
            if (pick == streamer_id_t'(`BRIDGE_STREAMERS - 1)) begin
                prio_q <= '0;
            end else begin
                prio_q <= streamer_id_t'(pick + 1'b1);
            end
        end
    end

endmodule

// File: hdl/tx_packetizer.sv
`include "bridge_macros.svh"

module tx_packetizer (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  bridge_pkg::tile_id_t  src_id_i,
    input  logic                  grant_valid_i,
    input  bridge_pkg::tcdm_req_t grant_req_i,
    input  logic                  noc_ready_i,
    output logic                  tx_idle_o,
    output logic                  noc_valid_o,
    output bridge_pkg::noc_beat_t noc_beat_o
);

    import bridge_pkg::*;

    tx_state_t  state_q;
    tx_state_t  state_d;
    logic       idle_q;
    opcode_t    op_q;
    word_addr_t waddr_q;
    tcdm_data_t wdata_q;
    tile_id_t   dst_tile;
    tcdm_data_t header;

    assign dst_tile = {tile_xy_t'(`BRIDGE_SPM_Y), tile_xy_t'(`BRIDGE_SPM_X)};

    // Short header, reserved bits zero
    always_comb begin
        header = '0;
        header[`BRIDGE_HDR_DST_HI:`BRIDGE_HDR_DST_LO]   = dst_tile;
        header[`BRIDGE_HDR_ADDR_HI:`BRIDGE_HDR_ADDR_LO] = waddr_q;
        header[`BRIDGE_HDR_SRC_HI:`BRIDGE_HDR_SRC_LO]   = src_id_i;
        header[`BRIDGE_HDR_PT]                          = 1'b0;
        header[`BRIDGE_HDR_OP_HI:`BRIDGE_HDR_OP_LO]     = op_q;
        header[`BRIDGE_HDR_HL]                          = 1'b0;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            TX_IDLE:   if (grant_valid_i) state_d = TX_HEADER;
            TX_HEADER: if (noc_ready_i) state_d = TX_DATA;
            TX_DATA:   if (noc_ready_i) state_d = TX_IDLE;
            default:   state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= TX_IDLE;
            idle_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // Idle copy stays low until the first clock after reset
            idle_q  <= (state_d == TX_IDLE);
        end
    end

    // Capture the granted request; reads carry a zero data beat
    always_ff @(posedge clk_i) begin
        if (state_q == TX_IDLE && grant_valid_i) begin
            waddr_q <= grant_req_i.addr[`BRIDGE_WADDR_LSB +: `BRIDGE_WADDR_W];
            if (grant_req_i.wen) begin
                op_q    <= opcode_t'(`BRIDGE_OP_MGET);
                wdata_q <= '0;
            end else begin
                op_q    <= opcode_t'(`BRIDGE_OP_MPUT);
                wdata_q <= grant_req_i.data;
            end
        end
    end

    assign tx_idle_o   = idle_q;
    assign noc_valid_o = (state_q != TX_IDLE);

    always_comb begin
        noc_beat_o.last = (state_q == TX_DATA);
        noc_beat_o.data = (state_q == TX_DATA) ? wdata_q : header;
    end

endmodule

// File: hdl/rx_depacketizer.sv
`include "bridge_macros.svh"

module rx_depacketizer (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   noc_valid_i,
    input  bridge_pkg::noc_beat_t  noc_beat_i,
    output logic                   noc_ready_o,
    output logic                   hdr_strobe_o,
    output bridge_pkg::word_addr_t hdr_addr_o,
    output logic                   data_strobe_o,
    output bridge_pkg::tcdm_data_t data_o
);

    import bridge_pkg::*;

    rx_state_t  state_q;
    logic       ready_q;
    logic       fire;
    logic       hdr_strobe_q;
    logic       data_strobe_q;
    word_addr_t hdr_addr_q;
    tcdm_data_t data_q;

    // Responses are never back-pressured once out of reset
    assign noc_ready_o = ready_q;
    assign fire        = noc_valid_i & ready_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= RX_HEADER;
            ready_q       <= 1'b0;
            hdr_strobe_q  <= 1'b0;
            data_strobe_q <= 1'b0;
        end else begin
            ready_q       <= 1'b1;
            hdr_strobe_q  <= fire && (state_q == RX_HEADER);
            data_strobe_q <= fire && (state_q == RX_DATA) && noc_beat_i.last;
            if (fire) begin
                case (state_q)
                    RX_HEADER: state_q <= RX_DATA;
                    RX_DATA:   if (noc_beat_i.last) state_q <= RX_HEADER;
                    default:   state_q <= RX_HEADER;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire && state_q == RX_HEADER) begin
            hdr_addr_q <= noc_beat_i.data[`BRIDGE_HDR_ADDR_HI:`BRIDGE_HDR_ADDR_LO];
        end
        if (fire && state_q == RX_DATA) begin
            data_q <= noc_beat_i.data;
        end
    end

    assign hdr_strobe_o  = hdr_strobe_q;
    assign hdr_addr_o    = hdr_addr_q;
    assign data_strobe_o = data_strobe_q;
    assign data_o        = data_q;

endmodule

// File: hdl/read_tracker.sv
`include "bridge_macros.svh"

module read_tracker (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           grant_valid_i,
    input  bridge_pkg::streamer_id_t                       grant_id_i,
    input  bridge_pkg::tcdm_req_t                          grant_req_i,
    input  logic                                           hdr_strobe_i,
    input  bridge_pkg::word_addr_t                         hdr_addr_i,
    input  logic                                           data_strobe_i,
    input  bridge_pkg::tcdm_data_t                         data_i,
    output bridge_pkg::streamer_vec_t                      room_o,
    output bridge_pkg::streamer_vec_t                      rvalid_o,
    output bridge_pkg::tcdm_data_t [`BRIDGE_STREAMERS-1:0] rdata_o
);

    import bridge_pkg::*;

    read_entry_t                         table_q [`BRIDGE_READ_SLOTS];
    logic [`BRIDGE_READ_SLOTS-1:0]       valid_q;
    slot_idx_t                           head_q;
    slot_idx_t                           tail_q;
    slot_count_t                         span_q;
    read_count_t [`BRIDGE_STREAMERS-1:0] count_q;
    logic                                append;
    logic                                retire;
    logic                                match_found;
    slot_idx_t                           match_idx;
    slot_idx_t                           scan_idx;
    logic                                hit_q;
    streamer_id_t                        hit_sid_q;
    streamer_vec_t                       issue;

    function automatic slot_idx_t slot_next(slot_idx_t p);
        slot_idx_t n;
        if (p == slot_idx_t'(`BRIDGE_READ_SLOTS - 1)) begin
            n = '0;
        end else begin
            n = slot_idx_t'(p + 1'b1);
        end
        return n;
    endfunction

    // Only reads enter the table
    assign append = grant_valid_i & grant_req_i.wen;

    // Head steps over slots already answered
    assign retire = (span_q != '0) && !valid_q[head_q];

    // Oldest valid entry with the same word address
    always_comb begin
        match_found = 1'b0;
        match_idx   = head_q;
        scan_idx    = head_q;
        for (int unsigned k = 0; k < `BRIDGE_READ_SLOTS; k++) begin
            scan_idx = slot_idx_t'((head_q + k) % `BRIDGE_READ_SLOTS);
            if (!match_found && valid_q[scan_idx] &&
                table_q[scan_idx].waddr == hdr_addr_i) begin
                match_found = 1'b1;
                match_idx   = scan_idx;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (append) begin
            table_q[tail_q].sid   <= grant_id_i;
            table_q[tail_q].waddr <= grant_req_i.addr[`BRIDGE_WADDR_LSB +: `BRIDGE_WADDR_W];
        end
        if (hdr_strobe_i) begin
            hit_sid_q <= table_q[match_idx].sid;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            span_q  <= '0;
            hit_q   <= 1'b0;
        end else begin
            if (append) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= slot_next(tail_q);
            end
            if (hdr_strobe_i) begin
                hit_q <= match_found;
                if (match_found) begin
                    valid_q[match_idx] <= 1'b0;
                end
            end
            if (retire) begin
                head_q <= slot_next(head_q);
            end
            if (append && !retire) begin
                span_q <= slot_count_t'(span_q + 1'b1);
            end else if (!append && retire) begin
                span_q <= slot_count_t'(span_q - 1'b1);
            end
        end
    end

    // Delivery to the streamer found at header time
    always_comb begin
        rvalid_o = '0;
        issue    = '0;
        if (data_strobe_i && hit_q) begin
            rvalid_o[hit_sid_q] = 1'b1;
        end
        if (append) begin
            issue[grant_id_i] = 1'b1;
        end
        for (int s = 0; s < `BRIDGE_STREAMERS; s++) begin
            rdata_o[s] = rvalid_o[s] ? data_i : '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else begin
            for (int s = 0; s < `BRIDGE_STREAMERS; s++) begin
                case ({issue[s], rvalid_o[s]})
                    2'b10:   count_q[s] <= read_count_t'(count_q[s] + 1'b1);
                    2'b01:   count_q[s] <= read_count_t'(count_q[s] - 1'b1);
                    default: count_q[s] <= count_q[s];
                endcase
            end
        end
    end

    // Table span must also leave a free slot at the tail
    always_comb begin
        for (int s = 0; s < `BRIDGE_STREAMERS; s++) begin
            room_o[s] = (count_q[s] < read_count_t'(`BRIDGE_MAX_READS)) &&
                        (span_q < slot_count_t'(`BRIDGE_READ_SLOTS));
        end
    end

endmodule

// File: hdl/tcdm_noc_bridge.sv
`include "bridge_macros.svh"

module tcdm_noc_bridge (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  bridge_pkg::tile_id_t                           src_id_i,
    input  bridge_pkg::streamer_vec_t                      tcdm_req_i,
    input  bridge_pkg::tcdm_req_t [`BRIDGE_STREAMERS-1:0]  tcdm_i,
    output bridge_pkg::streamer_vec_t                      tcdm_gnt_o,
    output bridge_pkg::streamer_vec_t                      tcdm_rvalid_o,
    output bridge_pkg::tcdm_data_t [`BRIDGE_STREAMERS-1:0] tcdm_rdata_o,
    output logic                                           noc_out_valid_o,
    output bridge_pkg::noc_beat_t                          noc_out_o,
    input  logic                                           noc_out_ready_i,
    input  logic                                           noc_in_valid_i,
    input  bridge_pkg::noc_beat_t                          noc_in_i,
    output logic                                           noc_in_ready_o
);

    import bridge_pkg::*;

    logic          grant_valid;
    streamer_id_t  grant_id;
    tcdm_req_t     grant_req;
    logic          tx_idle;
    streamer_vec_t room;
    logic          hdr_strobe;
    word_addr_t    hdr_addr;
    logic          data_strobe;
    tcdm_data_t    rx_data;

    req_arbiter u_arbiter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_i         (tcdm_req_i),
        .reqs_i        (tcdm_i),
        .room_i        (room),
        .tx_idle_i     (tx_idle),
        .gnt_o         (tcdm_gnt_o),
        .grant_valid_o (grant_valid),
        .grant_id_o    (grant_id),
        .grant_req_o   (grant_req)
    );

    tx_packetizer u_tx (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .src_id_i      (src_id_i),
        .grant_valid_i (grant_valid),
        .grant_req_i   (grant_req),
        .noc_ready_i   (noc_out_ready_i),
        .tx_idle_o     (tx_idle),
        .noc_valid_o   (noc_out_valid_o),
        .noc_beat_o    (noc_out_o)
    );

    rx_depacketizer u_rx (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .noc_valid_i   (noc_in_valid_i),
        .noc_beat_i    (noc_in_i),
        .noc_ready_o   (noc_in_ready_o),
        .hdr_strobe_o  (hdr_strobe),
        .hdr_addr_o    (hdr_addr),
        .data_strobe_o (data_strobe),
        .data_o        (rx_data)
    );

    read_tracker u_tracker (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .grant_valid_i (grant_valid),
        .grant_id_i    (grant_id),
        .grant_req_i   (grant_req),
        .hdr_strobe_i  (hdr_strobe),
        .hdr_addr_i    (hdr_addr),
        .data_strobe_i (data_strobe),
        .data_i        (rx_data),
        .room_o        (room),
        .rvalid_o      (tcdm_rvalid_o),
        .rdata_o       (tcdm_rdata_o)
    );

endmodule

// File: verif/bridge_tb.sv
`include "bridge_macros.svh"

module bridge_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import bridge_pkg::*;

    localparam int N          = `BRIDGE_STREAMERS;
    localparam int NUM_REQS   = 300;
    localparam int MAX_CYCLES = NUM_REQS * 40;
    localparam int DRIVE_DLY  = 2;
    localparam tile_id_t SPM_TILE = {tile_xy_t'(`BRIDGE_SPM_Y), tile_xy_t'(`BRIDGE_SPM_X)};

    // One outstanding read as the model sees it
    typedef struct packed {
        streamer_id_t sid;
        word_addr_t   waddr;
        logic         sent;
    } pend_t;

    logic               clk;
    logic               rst_n;
    tile_id_t           src_id;
    streamer_vec_t      tcdm_req;
    tcdm_req_t [N-1:0]  tcdm_in;
    streamer_vec_t      tcdm_gnt;
    streamer_vec_t      tcdm_rvalid;
    tcdm_data_t [N-1:0] tcdm_rdata;
    logic               noc_out_valid;
    noc_beat_t          noc_out;
    logic               noc_out_ready;
    logic               noc_in_valid;
    noc_beat_t          noc_in;
    logic               noc_in_ready;

    // Reference model state
    tcdm_data_t    mem [word_addr_t];
    pend_t         pending [$];
    int            reads [N];
    int            prio;
    int            issued;
    int            grants;
    int            cycles;
    streamer_vec_t granted;
    int            tx_stage;
    logic          pkt_read;
    word_addr_t    pkt_waddr;
    tcdm_data_t    pkt_hdr;
    tcdm_data_t    pkt_data;
    int            resp_stage;
    word_addr_t    resp_addr;
    tcdm_data_t    resp_data;
    logic          resp_hit;
    streamer_id_t  resp_sid;
    logic          deliver_due;
    logic          deliver_hit;
    streamer_id_t  deliver_sid;
    tcdm_data_t    deliver_data;
    logic          finished;

    tcdm_noc_bridge uut (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .src_id_i        (src_id),
        .tcdm_req_i      (tcdm_req),
        .tcdm_i          (tcdm_in),
        .tcdm_gnt_o      (tcdm_gnt),
        .tcdm_rvalid_o   (tcdm_rvalid),
        .tcdm_rdata_o    (tcdm_rdata),
        .noc_out_valid_o (noc_out_valid),
        .noc_out_o       (noc_out),
        .noc_out_ready_i (noc_out_ready),
        .noc_in_valid_i  (noc_in_valid),
        .noc_in_i        (noc_in),
        .noc_in_ready_o  (noc_in_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_beat(noc_beat_t exp);
        if (noc_out !== exp) begin
            report_error($sformatf("NoC beat data %h last %b, expected data %h last %b",
                                   noc_out.data, noc_out.last, exp.data, exp.last));
        end
    endtask

    task automatic check_rdata(streamer_id_t sid, tcdm_data_t exp);
        if (tcdm_rdata[sid] !== exp) begin
            report_error($sformatf("streamer %0d read data %h, expected %h",
                                   sid, tcdm_rdata[sid], exp));
        end
    endtask

    task automatic verify_mask(streamer_vec_t got, streamer_vec_t exp, string what);
        if (got !== exp) begin
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // Short header: reserved, HL, opcode, PT, source, word address, destination
    function automatic tcdm_data_t make_header(opcode_t op, tile_id_t src, word_addr_t wa,
                                               tile_id_t dst);
        return {3'b000, 1'b0, op, 1'b0, src, wa, dst};
    endfunction

    function automatic tcdm_data_t mem_read(word_addr_t a);
        tcdm_data_t v;
        if (mem.exists(a)) begin
            v = mem[a];
        end else begin
            v = {4'hc, a, 4'h3, ~a};
        end
        return v;
    endfunction

    // Round-robin choice among requesting streamers below the read limit
    function automatic int expected_pick();
        int idx;
        for (int k = 0; k < N; k++) begin
            idx = (prio + k) % N;
            if (tcdm_req[idx] && reads[idx] < `BRIDGE_MAX_READS) begin
                return idx;
            end
        end
        return -1;
    endfunction

    // Runs at the falling edge, where every DUT output is settled
    task automatic sample_cycle();
        logic          busy;
        int            pick;
        int            hit;
        noc_beat_t     exp_beat;
        streamer_vec_t exp_vec;
        tcdm_req_t     req;
        busy = (tx_stage != 0);
        if (tx_stage != 0) begin
            if (!noc_out_valid) begin
                report_error("NoC output valid dropped before the beat was accepted");
            end
            exp_beat.data = (tx_stage == 1) ? pkt_hdr : pkt_data;
            exp_beat.last = (tx_stage == 2);
            check_beat(exp_beat);
            if (noc_out_ready && tx_stage == 1) begin
                tx_stage = 2;
            end else if (noc_out_ready) begin
                tx_stage = 0;
                if (pkt_read) begin
                    pending[pending.size() - 1].sent = 1'b1;
                end else begin
                    mem[pkt_waddr] = pkt_data;
                end
            end
        end else if (noc_out_valid) begin
            report_error("NoC output valid without a granted request");
        end
        exp_vec = '0;
        if (tcdm_gnt != '0) begin
            if (busy) begin
                report_error("grant while a packet is still being sent");
            end
            pick = expected_pick();
            if (pick < 0) begin
                report_error("grant with no requesting streamer that has room");
            end
            exp_vec[pick] = 1'b1;
            verify_mask(tcdm_gnt, exp_vec, "tcdm_gnt_o");
            req       = tcdm_in[pick];
            pkt_read  = req.wen;
            pkt_waddr = req.addr[`BRIDGE_WADDR_LSB +: `BRIDGE_WADDR_W];
            pkt_data  = req.wen ? '0 : req.data;
            pkt_hdr   = make_header(req.wen ? opcode_t'(`BRIDGE_OP_MGET) :
                                    opcode_t'(`BRIDGE_OP_MPUT), src_id, pkt_waddr, SPM_TILE);
            tx_stage  = 1;
            if (req.wen) begin
                reads[pick]++;
                pending.push_back('{sid: streamer_id_t'(pick), waddr: pkt_waddr, sent: 1'b0});
            end
            prio          = (pick + 1) % N;
            granted[pick] = 1'b1;
            grants++;
        end
        // Delivery falls one cycle after the response data beat
        exp_vec = '0;
        if (deliver_due && deliver_hit) begin
            exp_vec[deliver_sid] = 1'b1;
        end
        verify_mask(tcdm_rvalid, exp_vec, "tcdm_rvalid_o");
        if (deliver_due && deliver_hit) begin
            check_rdata(deliver_sid, deliver_data);
            reads[deliver_sid]--;
        end
        deliver_due = 1'b0;
        if (noc_in_valid && noc_in_ready && resp_stage == 1) begin
            resp_hit = 1'b0;
            hit      = 0;
            for (int i = 0; i < pending.size(); i++) begin
                if (!resp_hit && pending[i].waddr == resp_addr) begin
                    resp_hit = 1'b1;
                    hit      = i;
                end
            end
            if (resp_hit) begin
                resp_sid = pending[hit].sid;
                pending.delete(hit);
            end
            resp_stage = 2;
        end else if (noc_in_valid && noc_in_ready) begin
            deliver_due  = 1'b1;
            deliver_hit  = resp_hit;
            deliver_sid  = resp_sid;
            deliver_data = resp_data;
            resp_stage   = 0;
        end
        finished = (grants == NUM_REQS) && (tx_stage == 0) && (pending.size() == 0) &&
                   (resp_stage == 0) && !deliver_due;
    endtask

    task automatic drive_cycle();
        int pool [$];
        int pick;
        for (int s = 0; s < N; s++) begin
            if (granted[s] || !tcdm_req[s]) begin
                tcdm_req[s] = 1'b0;
                if (issued < NUM_REQS && $urandom_range(0, 1) == 1) begin
                    tcdm_in[s].addr = $urandom;
                    // Small word range so that addresses repeat
                    tcdm_in[s].addr[`BRIDGE_WADDR_LSB +: `BRIDGE_WADDR_W] =
                        word_addr_t'($urandom_range(0, 7));
                    tcdm_in[s].wen  = $urandom_range(0, 1);
                    tcdm_in[s].data = $urandom;
                    tcdm_req[s]     = 1'b1;
                    issued++;
                end
            end
        end
        granted       = '0;
        noc_out_ready = ($urandom_range(0, 3) != 0);
        if (resp_stage == 0 && $urandom_range(0, 2) == 0) begin
            foreach (pending[i]) begin
                if (pending[i].sent) begin
                    pool.push_back(i);
                end
            end
            if (pool.size() > 0 && $urandom_range(0, 7) != 0) begin
                pick       = pool[$urandom_range(0, pool.size() - 1)];
                resp_addr  = pending[pick].waddr;
                resp_data  = mem_read(resp_addr);
                resp_stage = 1;
            end else if (grants < NUM_REQS && $urandom_range(0, 3) == 0) begin
                // Address that no streamer ever reads
                resp_addr  = word_addr_t'(12'h800 + $urandom_range(0, 255));
                resp_data  = $urandom;
                resp_stage = 1;
            end
        end
        noc_in_valid = (resp_stage == 1) || (resp_stage == 2 && $urandom_range(0, 3) != 0);
        noc_in.data  = (resp_stage == 1) ?
                       make_header(opcode_t'(`BRIDGE_OP_MPUT), SPM_TILE, resp_addr, src_id) :
                       resp_data;
        noc_in.last  = (resp_stage == 2);
    endtask

    initial begin
        void'($urandom(30));
        rst_n         = 1'b0;
        src_id        = tile_id_t'($urandom_range(0, 63));
        tcdm_req      = '0;
        tcdm_in       = '0;
        noc_out_ready = 1'b0;
        noc_in_valid  = 1'b0;
        noc_in        = '0;
        reads         = '{default: 0};
        prio          = 0;
        issued        = 0;
        grants        = 0;
        cycles        = 0;
        granted       = '0;
        tx_stage      = 0;
        resp_stage    = 0;
        resp_hit      = 1'b0;
        deliver_due   = 1'b0;
        finished      = 1'b0;
        repeat (10) begin
            @(negedge clk);
            if (tcdm_gnt != '0 || tcdm_rvalid != '0 || noc_out_valid || noc_in_ready) begin
                report_error("outputs not low during reset");
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        while (!finished) begin
            @(negedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("Timeout: only %0d of %0d requests granted and answered after %0d cycles",
                         grants, NUM_REQS, MAX_CYCLES);
                abort_run();
            end
            sample_cycle();
            @(posedge clk);
            #DRIVE_DLY;
            drive_cycle();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: sim.f
+incdir+hdl
hdl/bridge_pkg.sv
hdl/req_arbiter.sv
hdl/tx_packetizer.sv
hdl/rx_depacketizer.sv
hdl/read_tracker.sv
hdl/tcdm_noc_bridge.sv
verif/bridge_tb.sv

// File: Bender.yml
package:
  name: tcdm_noc_bridge

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bridge_pkg.sv
      - hdl/req_arbiter.sv
      - hdl/tx_packetizer.sv
      - hdl/rx_depacketizer.sv
      - hdl/read_tracker.sv
      - hdl/tcdm_noc_bridge.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/bridge_tb.sv
